// File: Makefile
LOG := sim.log

help:
	@echo "targets:"
	@echo "  test   build tb_lsq with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lsq -f sources.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// File: data_ram.sv
module data_ram
	import lsq_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  mem_read,
	input  logic  mem_write,
	input  word_t mem_address,
	input  be_t   byte_enable,
	input  word_t wdata,
	output logic  mem_resp,
	output word_t mem_rdata
);

	word_t mem [ram_words] = '{default: '0};

	ram_addr_t word_idx;
	ram_cnt_t  count;
	logic      req;
	logic      req_d;
	logic      fire;

	assign req      = mem_read || mem_write;
	assign word_idx = mem_address[$bits(ram_addr_t)+1:2];

	// last cycle of the countdown
	assign fire = (count == ram_cnt_t'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			req_d    <= 1'b0;
			count    <= '0;
			mem_resp <= 1'b0;
		end else begin
			req_d    <= req;
			mem_resp <= fire;
			// new request only on a rising level
			if (req && !req_d)
				count <= ram_cnt_t'(ram_latency - 1);
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	// read and byte writes land together with the response
	always_ff @(posedge clk) begin
		if (fire) begin
			mem_rdata <= mem[word_idx];
			if (mem_write) begin
				for (int b = 0; b < 4; b++) begin
					if (byte_enable[b])
						mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: load_store_queue.sv
module load_store_queue
	import lsq_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       flush,

	input  logic       disp_valid,
	input  mem_op_t    disp_op,
	input  funct3_t    disp_funct3,
	input  word_t      disp_imm,
	input  rob_tag_t   disp_tag,
	input  word_t      base,
	input  logic       base_busy,
	input  word_t      store_data,
	input  logic       store_busy,

	input  logic       cdb_valid,
	input  rob_tag_t   cdb_tag,
	input  word_t      cdb_data,

	input  rob_tag_t   rob_head_tag,

	input  logic       mem_resp,
	input  word_t      load_value,

	output logic       lsq_full,
	output logic       res_valid,
	output rob_tag_t   res_tag,
	output word_t      res_data,

	output logic       mem_read,
	output logic       mem_write,
	output word_t      mem_address,
	output funct3_t    head_funct3,
	output logic [1:0] byte_offset,
	output word_t      store_word
);

	typedef enum logic {
		idle,
		wait_resp
	} lsq_state_t;

	lsq_state_t state;

	// entry storage, valid range given by head and count
	mem_op_t  ent_op        [lsq_depth];
	funct3_t  ent_funct3    [lsq_depth];
	rob_tag_t ent_tag       [lsq_depth];
	word_t    ent_imm       [lsq_depth];
	word_t    ent_addr      [lsq_depth];
	logic     ent_addr_busy [lsq_depth];
	word_t    ent_data      [lsq_depth];
	logic     ent_data_busy [lsq_depth];

	lsq_idx_t head;
	lsq_idx_t tail;
	lsq_cnt_t count;

	logic enq;
	logic deq;
	logic head_ready;
	logic issue;
	logic killed;
	logic base_hit;
	logic data_hit;

	assign lsq_full = (count == lsq_cnt_t'(lsq_depth));
	assign enq      = disp_valid && !lsq_full && !flush;

	// a killed access was flushed away, its head slot is already gone
	assign deq = (state == wait_resp) && mem_resp && !killed && !flush;

	// operand broadcast in the dispatch cycle itself
	assign base_hit = base_busy && cdb_valid && (cdb_tag == base[3:0]);
	assign data_hit = store_busy && cdb_valid && (cdb_tag == store_data[3:0]);

	always_comb begin
		head_ready = (count != '0) && !ent_addr_busy[head];
		// stores wait until they are the oldest in the machine
		if (ent_op[head] == op_store) begin
			head_ready = head_ready && !ent_data_busy[head] &&
				(ent_tag[head] == rob_head_tag);
		end
	end

	assign issue = (state == idle) && head_ready && !flush;

	// wake-up and dispatch write
	always_ff @(posedge clk) begin
		for (int i = 0; i < lsq_depth; i++) begin
			if (cdb_valid && ent_addr_busy[i] && (cdb_tag == ent_addr[i][3:0])) begin
				ent_addr[i]      <= cdb_data + ent_imm[i];
				ent_addr_busy[i] <= 1'b0;
			end
			if (cdb_valid && ent_data_busy[i] && (cdb_tag == ent_data[i][3:0])) begin
				ent_data[i]      <= cdb_data;
				ent_data_busy[i] <= 1'b0;
			end
		end

		if (enq) begin
			ent_op[tail]     <= disp_op;
			ent_funct3[tail] <= disp_funct3;
			ent_tag[tail]    <= disp_tag;
			ent_imm[tail]    <= disp_imm;

			if (base_hit) begin
				ent_addr[tail]      <= cdb_data + disp_imm;
				ent_addr_busy[tail] <= 1'b0;
			end else if (base_busy) begin
				// holds the producer tag until the bus delivers
				ent_addr[tail]      <= base;
				ent_addr_busy[tail] <= 1'b1;
			end else begin
				ent_addr[tail]      <= base + disp_imm;
				ent_addr_busy[tail] <= 1'b0;
			end

			// loads never wait on data
			ent_data[tail]      <= data_hit ? cdb_data : store_data;
			ent_data_busy[tail] <= (disp_op == op_store) && store_busy && !data_hit;
		end
	end

	// queue pointers and head issue
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= idle;
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
			res_valid <= 1'b0;
			killed    <= 1'b0;
		end else begin
			res_valid <= 1'b0;

			if (flush) begin
				head  <= '0;
				tail  <= '0;
				count <= '0;
			end else begin
				if (enq)
					tail <= tail + 1'b1;
				if (deq)
					head <= head + 1'b1;
				count <= count + lsq_cnt_t'(enq) - lsq_cnt_t'(deq);
			end

			case (state)
				idle: begin
					if (issue) begin
						state     <= wait_resp;
						mem_read  <= (ent_op[head] == op_load);
						mem_write <= (ent_op[head] == op_store);
					end
				end
				wait_resp: begin
					// access completes in memory but reports nothing
					if (flush)
						killed <= 1'b1;
					if (mem_resp) begin
						state     <= idle;
						mem_read  <= 1'b0;
						mem_write <= 1'b0;
						killed    <= 1'b0;
						res_valid <= !killed && !flush;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// request held stable while the head may be overwritten after a flush
	always_ff @(posedge clk) begin
		if (issue) begin
			mem_address <= {ent_addr[head][31:2], 2'b00};
			byte_offset <= ent_addr[head][1:0];
			head_funct3 <= ent_funct3[head];
			store_word  <= ent_data[head];
		end
		if (mem_resp) begin
			res_tag  <= ent_tag[head];
			res_data <= mem_read ? load_value : store_word;
		end
	end

endmodule

// File: lsq_checker.sv
module lsq_checker
	import lsq_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       flush,
	input logic       disp_valid,
	input logic       lsq_full,
	input logic       mem_read,
	input logic       mem_write,
	input logic       mem_resp,
	input word_t      mem_address,
	input logic [1:0] byte_offset,
	input funct3_t    head_funct3,
	input word_t      store_word,
	input logic       res_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// one access at a time
	one_access: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
		else $error("read and write requested together");

	// request held from issue until the response
	request_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && !mem_resp |=>
		$stable(mem_read) && $stable(mem_write) && $stable(mem_address) &&
		$stable(byte_offset) && $stable(head_funct3) && $stable(store_word))
		else $error("memory request changed before its response");

	quiet_after_flush: assert property (@(posedge clk) disable iff (rst)
		flush |=> !res_valid)
		else $error("result reported right after a flush");

	no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
		disp_valid |-> !lsq_full)
		else $error("dispatch while the queue is full");

endmodule

// File: lsq_pkg.sv
package lsq_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  rob_tag_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [3:0]  be_t;

	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} mem_op_t;

	// width field of loads and stores, rv32i values
	localparam funct3_t f3_b  = 3'b000;
	localparam funct3_t f3_h  = 3'b001;
	localparam funct3_t f3_w  = 3'b010;
	localparam funct3_t f3_bu = 3'b100;
	localparam funct3_t f3_hu = 3'b101;

	// queue geometry
	localparam int lsq_depth = 8;

	typedef logic [$clog2(lsq_depth)-1:0] lsq_idx_t;
	typedef logic [$clog2(lsq_depth):0]   lsq_cnt_t;

	// data memory
	localparam int ram_words   = 256;
	localparam int ram_latency = 2;

	typedef logic [$clog2(ram_words)-1:0]     ram_addr_t;
	typedef logic [$clog2(ram_latency+1)-1:0] ram_cnt_t;

endpackage

// File: lsq_top.sv
module lsq_top
	import lsq_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,

	input  logic     disp_valid,
	input  mem_op_t  disp_op,
	input  funct3_t  disp_funct3,
	input  word_t    disp_imm,
	input  rob_tag_t disp_tag,
	input  word_t    base,
	input  logic     base_busy,
	input  word_t    store_data,
	input  logic     store_busy,

	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  word_t    cdb_data,

	input  rob_tag_t rob_head_tag,

	output logic     lsq_full,
	output logic     res_valid,
	output rob_tag_t res_tag,
	output word_t    res_data
);

	logic       mem_read;
	logic       mem_write;
	logic       mem_resp;
	word_t      mem_address;
	word_t      mem_rdata;
	funct3_t    head_funct3;
	logic [1:0] byte_offset;
	word_t      store_word;
	word_t      load_value;
	be_t        byte_enable;
	word_t      wdata_lanes;

	load_store_queue lsq0 (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.disp_valid   (disp_valid),
		.disp_op      (disp_op),
		.disp_funct3  (disp_funct3),
		.disp_imm     (disp_imm),
		.disp_tag     (disp_tag),
		.base         (base),
		.base_busy    (base_busy),
		.store_data   (store_data),
		.store_busy   (store_busy),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.rob_head_tag (rob_head_tag),
		.mem_resp     (mem_resp),
		.load_value   (load_value),
		.lsq_full     (lsq_full),
		.res_valid    (res_valid),
		.res_tag      (res_tag),
		.res_data     (res_data),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_address  (mem_address),
		.head_funct3  (head_funct3),
		.byte_offset  (byte_offset),
		.store_word   (store_word)
	);

	mem_align align0 (
		.funct3      (head_funct3),
		.byte_offset (byte_offset),
		.rdata       (mem_rdata),
		.wdata       (store_word),
		.load_value  (load_value),
		.byte_enable (byte_enable),
		.wdata_lanes (wdata_lanes)
	);

	data_ram ram0 (
		.clk         (clk),
		.rst         (rst),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_address (mem_address),
		.byte_enable (byte_enable),
		.wdata       (wdata_lanes),
		.mem_resp    (mem_resp),
		.mem_rdata   (mem_rdata)
	);

endmodule

// File: mem_align.sv
module mem_align
	import lsq_pkg::*;
(
	input  funct3_t    funct3,
	input  logic [1:0] byte_offset,
	input  word_t      rdata,
	input  word_t      wdata,
	output word_t      load_value,
	output be_t        byte_enable,
	output word_t      wdata_lanes
);

	logic [4:0] shift;
	word_t      rdata_shifted;

	// byte offset in bits
	assign shift = {byte_offset, 3'b000};

	assign rdata_shifted = rdata >> shift;
	assign wdata_lanes   = wdata << shift;

	// load extension
	always_comb begin
		case (funct3)
			f3_b:    load_value = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
			f3_h:    load_value = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
			f3_bu:   load_value = {24'd0, rdata_shifted[7:0]};
			f3_hu:   load_value = {16'd0, rdata_shifted[15:0]};
			f3_w:    load_value = rdata_shifted;
			default: load_value = rdata_shifted;
		endcase
	end

	// store lanes, sb/sh/sw share the load codes
	always_comb begin
		case (funct3)
			f3_b:    byte_enable = be_t'(4'b0001 << byte_offset);
			f3_h:    byte_enable = be_t'(4'b0011 << byte_offset);
			default: byte_enable = 4'b1111;
		endcase
	end

endmodule

// File: sources.f
lsq_pkg.sv
mem_align.sv
load_store_queue.sv
data_ram.sv
lsq_top.sv
lsq_checker.sv
tb_lsq.sv

// File: tb_lsq.sv
module tb_lsq
	import lsq_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic       is_store;
		funct3_t    f3;
		rob_tag_t   tag;
		logic [9:0] addr;
		word_t      data;
	} exp_op_t;

	logic     clk;
	logic     rst;
	logic     flush;
	logic     disp_valid;
	mem_op_t  disp_op;
	funct3_t  disp_funct3;
	word_t    disp_imm;
	rob_tag_t disp_tag;
	word_t    base;
	logic     base_busy;
	word_t    store_data;
	logic     store_busy;
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	word_t    cdb_data;
	rob_tag_t rob_head_tag;
	logic     lsq_full;
	logic     res_valid;
	rob_tag_t res_tag;
	word_t    res_data;

	// reference state
	logic [7:0]  model_mem [ram_words*4];
	exp_op_t     expq [$];
	word_t       prod_value [4];
	logic        prod_pending [4];
	rob_tag_t    next_tag;
	int          ops_left;
	int          full_cycles;
	logic [31:0] lfsr;

	lsq_top dut0 (.*);

	bind load_store_queue lsq_checker chk0 (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.disp_valid  (disp_valid),
		.lsq_full    (lsq_full),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_resp    (mem_resp),
		.mem_address (mem_address),
		.byte_offset (byte_offset),
		.head_funct3 (head_funct3),
		.store_word  (store_word),
		.res_valid   (res_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// extension rules of rv32i loads
	function automatic word_t load_model(input funct3_t f3, input logic [9:0] a);
		case (f3)
			f3_b:    return {{24{model_mem[a][7]}}, model_mem[a]};
			f3_bu:   return {24'd0, model_mem[a]};
			f3_h:    return {{16{model_mem[a + 10'd1][7]}}, model_mem[a + 10'd1], model_mem[a]};
			f3_hu:   return {16'd0, model_mem[a + 10'd1], model_mem[a]};
			default: return {model_mem[a + 10'd3], model_mem[a + 10'd2],
				model_mem[a + 10'd1], model_mem[a]};
		endcase
	endfunction

	task automatic store_model(input exp_op_t e);
		int         n;
		logic [9:0] a;
		n = (e.f3 == f3_b) ? 1 : (e.f3 == f3_h) ? 2 : 4;
		for (int i = 0; i < n; i++) begin
			a = e.addr + 10'(i);
			model_mem[a] = e.data[8*i +: 8];
		end
	endtask

	// an outside producer keeps its value until broadcast
	function automatic word_t claim_producer(input logic [1:0] p, input word_t fresh);
		if (!prod_pending[p]) begin
			prod_value[p]   = fresh;
			prod_pending[p] = 1'b1;
		end
		return prod_value[p];
	endfunction

	task automatic broadcast(input logic [1:0] p);
		cdb_valid       = 1'b1;
		cdb_tag         = {2'b11, p};
		cdb_data        = prod_value[p];
		prod_pending[p] = 1'b0;
	endtask

	task automatic dispatch_random();
		exp_op_t    e;
		word_t      b;
		word_t      imm;
		word_t      k;
		logic [1:0] off;
		logic [1:0] bp;
		logic [1:0] dp;
		logic       use_b;
		logic       use_d;
		e.is_store = 1'(rand_bits(1));
		k = rand_bits(3) % 5;
		if (e.is_store)
			e.f3 = funct3_t'(rand_bits(2) % 3);
		else
			e.f3 = funct3_t'(k < 3 ? k : k + 1);
		// keep accesses naturally aligned
		off = 2'(rand_bits(2));
		if (e.f3 == f3_h || e.f3 == f3_hu)
			off[0] = 1'b0;
		else if (e.f3 == f3_w)
			off = 2'b00;
		imm   = (rand_bits(7) << 2) | {30'd0, off};
		use_b = (rand_bits(2) == 0);
		bp    = {1'b0, 1'(rand_bits(1))};
		if (use_b) begin
			b         = claim_producer(bp, rand_bits(7) << 2);
			base      = {28'd0, 2'b11, bp};
			base_busy = 1'b1;
		end else begin
			b         = rand_bits(7) << 2;
			base      = b;
			base_busy = 1'b0;
		end
		e.addr     = 10'(b + imm);
		e.data     = rand_bits(32);
		store_data = e.data;
		store_busy = 1'b0;
		use_d      = e.is_store && (rand_bits(2) == 0);
		dp         = {1'b1, 1'(rand_bits(1))};
		if (use_d) begin
			e.data     = claim_producer(dp, e.data);
			store_data = {28'd0, 2'b11, dp};
			store_busy = 1'b1;
		end
		e.tag       = next_tag;
		next_tag    = (next_tag == 4'd11) ? 4'd0 : next_tag + 4'd1;
		disp_valid  = 1'b1;
		disp_op     = e.is_store ? op_store : op_load;
		disp_funct3 = e.f3;
		disp_imm    = imm;
		disp_tag    = e.tag;
		expq.push_back(e);
		ops_left--;
		// wake-up in the dispatch cycle itself
		if (use_b && rand_bits(1) == 1)
			broadcast(bp);
		else if (use_d && rand_bits(1) == 1)
			broadcast(dp);
	endtask

	task automatic random_broadcast();
		logic [1:0] p;
		p = 2'(rand_bits(2));
		if (prod_pending[p] && rand_bits(1) == 1)
			broadcast(p);
	endtask

	// one clock of checking and stimulus at the falling edge
	task automatic step(input logic allow_disp);
		exp_op_t e;
		@(negedge clk);
		if (res_valid) begin
			if (expq.size() == 0) begin
				$display("a result appeared with no operation outstanding");
				stop_run();
			end
			e = expq.pop_front();
			check("res_tag", word_t'(res_tag), word_t'(e.tag));
			if (e.is_store) begin
				check("store res_data", res_data, e.data);
				store_model(e);
			end else begin
				check("load res_data", res_data, load_model(e.f3, e.addr));
			end
		end
		check("lsq_full", word_t'(lsq_full), word_t'(expq.size() == lsq_depth));
		if (lsq_full)
			full_cycles++;
		disp_valid = 1'b0;
		cdb_valid  = 1'b0;
		if (allow_disp && !lsq_full && ops_left > 0 && rand_bits(2) != 0)
			dispatch_random();
		if (!cdb_valid)
			random_broadcast();
		rob_head_tag = (expq.size() != 0) ? expq[0].tag : next_tag;
	endtask

	task automatic run_ops(input int n);
		int cycles;
		ops_left = n;
		cycles   = 0;
		while (ops_left > 0) begin
			step(1'b1);
			cycles++;
			if (cycles > 50 * n) begin
				$display("timed out while dispatching operations");
				stop_run();
			end
		end
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (expq.size() != 0) begin
			step(1'b0);
			cycles++;
			if (cycles > 3000) begin
				$display("timed out waiting for outstanding results");
				stop_run();
			end
		end
	endtask

	// flush while a store sits in memory
	task automatic flush_with_store(input logic late);
		int      cycles;
		exp_op_t e;
		ops_left = 1000;
		cycles   = 0;
		while (!dut0.mem_write) begin
			step(1'b1);
			cycles++;
			if (cycles > 2000) begin
				$display("timed out waiting for a store to issue");
				stop_run();
			end
		end
		ops_left = 0;
		step(1'b0);
		// a late flush meets the memory response
		if (late)
			step(1'b0);
		e = expq[0];
		check("head of queue is a store", word_t'(e.is_store), 32'd1);
		store_model(e);
		expq.delete();
		rob_head_tag = next_tag;
		flush        = 1'b1;
		@(negedge clk);
		flush     = 1'b0;
		cdb_valid = 1'b0;
		check("res_valid after flush", word_t'(res_valid), 32'd0);
		repeat (ram_latency + 3) step(1'b0);
	endtask

	initial begin
		lfsr        = 32'h5f6b_3451;
		next_tag    = '0;
		ops_left    = 0;
		full_cycles = 0;
		for (int i = 0; i < ram_words * 4; i++)
			model_mem[i] = 8'h00;
		for (int p = 0; p < 4; p++) begin
			prod_pending[p] = 1'b0;
			prod_value[p]   = '0;
		end
		rst          = 1'b1;
		flush        = 1'b0;
		disp_valid   = 1'b0;
		disp_op      = op_load;
		disp_funct3  = f3_w;
		disp_imm     = '0;
		disp_tag     = '0;
		base         = '0;
		base_busy    = 1'b0;
		store_data   = '0;
		store_busy   = 1'b0;
		cdb_valid    = 1'b0;
		cdb_tag      = '0;
		cdb_data     = '0;
		rob_head_tag = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		run_ops(400);
		drain();
		for (int i = 0; i < 3; i++) begin
			flush_with_store(1'(i % 2));
			run_ops(80);
			drain();
		end

		if (full_cycles == 0) begin
			$display("lsq_full never rose during the run");
			stop_run();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
